// ==== bench/serv_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_tb;

   localparam int N_ROWS = 37;
   localparam logic [31:0] SEED = 32'h11a6_e26f;

   typedef enum logic [3:0] {
      I_ADDI, I_XORI, I_ORI, I_ANDI, I_ADD, I_SUB, I_XOR, I_OR, I_AND,
      I_LUI, I_JAL, I_BEQ, I_BNE, I_LW, I_SW
   } mnem_e;

   typedef struct packed {
      mnem_e op;
      int    rd;
      int    rs1;
      int    rs2;
      int    imm;
   } row_t;

   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic        we;
   } dbus_t;

   // Program rows of op, rd, rs1, rs2 and imm (LUI takes the upper 20 bits)
   row_t rows [N_ROWS] = '{
      '{I_ADDI,  1,  0,  0, 128},
      '{I_ADDI,  2,  0,  0, -5},
      '{I_ADDI,  3,  0,  0, 1000},
      '{I_ADD,   4,  2,  3, 0},
      '{I_SUB,   5,  2,  3, 0},
      '{I_XORI,  6,  3,  0, -1},
      '{I_ORI,   7,  3,  0, 'h123},
      '{I_ANDI,  8,  3,  0, 'h2aa},
      '{I_LUI,   9,  0,  0, 'hdeadb},
      '{I_XOR,  10,  9,  2, 0},
      '{I_AND,  11,  6,  2, 0},
      '{I_OR,   12,  9,  8, 0},
      '{I_ADDI,  0,  3,  0, 77},
      '{I_SW,    0,  1,  4, 0},
      '{I_SW,    0,  1,  5, -4},
      '{I_SW,    0,  1,  7, 4},
      '{I_SW,    0,  1, 10, 8},
      '{I_SW,    0,  1, 11, 12},
      '{I_SW,    0,  1, 12, 16},
      '{I_SW,    0,  1,  0, 20},
      '{I_LW,   13,  1,  0, -64},
      '{I_SW,    0,  1, 13, 24},
      '{I_BEQ,   0,  2,  3, 8},
      '{I_BNE,   0,  2,  3, 8},
      '{I_SW,    0,  1,  2, 28},
      '{I_BEQ,   0,  4,  4, 8},
      '{I_SW,    0,  1,  3, 32},
      '{I_BNE,   0,  1,  1, 8},
      '{I_JAL,  14,  0,  0, 8},
      '{I_ADDI,  0,  0,  0, 0},
      '{I_SW,    0,  1, 14, 36},
      '{I_ADDI, 15,  0,  0, 3},
      '{I_ADDI, 16, 16,  0, 5},
      '{I_ADDI, 15, 15,  0, -1},
      '{I_BNE,   0, 15,  0, -8},
      '{I_SW,    0,  1, 16, 40},
      '{I_JAL,   0,  0,  0, 0}
   };

   logic        clk;
   logic        arst_n = 1'b0;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic [31:0] ibus_rdt = '0;
   logic        ibus_ack = 1'b0;
   logic [31:0] o_dbus_adr;
   logic [31:0] o_dbus_dat;
   logic        o_dbus_we;
   logic        o_dbus_cyc;
   logic [31:0] dbus_rdt = '0;
   logic        dbus_ack = 1'b0;

   logic [31:0] imem [64];
   logic [31:0] dmem [64];
   logic [31:0] exp_fetch [$];
   dbus_t       exp_dbus [$];
   dbus_t       dbus_exp;
   logic [31:0] delay_rng = SEED;
   logic [1:0]  ibus_wait;
   logic [1:0]  dbus_wait;
   logic        fetch_done = 1'b0;
   int          model_steps = 0;
   int          max_cycles = 0;
   int          checks = 0;
   int          errors = 0;

   serv_top u_serv_top (
      .clk        (clk),
      .i_arst_n   (arst_n),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_we  (o_dbus_we),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_rdt (dbus_rdt),
      .i_dbus_ack (dbus_ack)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // RV32I instruction formats
   function automatic logic [31:0] encode(input row_t r);
      logic [31:0] i;
      logic [4:0]  d;
      logic [4:0]  s1;
      logic [4:0]  s2;
      i  = r.imm;
      d  = r.rd[4:0];
      s1 = r.rs1[4:0];
      s2 = r.rs2[4:0];
      case (r.op)
         I_ADDI:  encode = {i[11:0], s1, 3'b000, d, 7'b0010011};
         I_XORI:  encode = {i[11:0], s1, 3'b100, d, 7'b0010011};
         I_ORI:   encode = {i[11:0], s1, 3'b110, d, 7'b0010011};
         I_ANDI:  encode = {i[11:0], s1, 3'b111, d, 7'b0010011};
         I_ADD:   encode = {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
         I_SUB:   encode = {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
         I_XOR:   encode = {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
         I_OR:    encode = {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
         I_AND:   encode = {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
         I_LUI:   encode = {i[19:0], d, 7'b0110111};
         I_JAL:   encode = {i[20], i[10:1], i[11], i[19:12], d, 7'b1101111};
         I_BEQ:   encode = {i[12], i[10:5], s2, s1, 3'b000, i[4:1], i[11], 7'b1100011};
         I_BNE:   encode = {i[12], i[10:5], s2, s1, 3'b001, i[4:1], i[11], 7'b1100011};
         I_LW:    encode = {i[11:0], s1, 3'b010, d, 7'b0000011};
         I_SW:    encode = {i[11:5], s2, s1, 3'b010, i[4:0], 7'b0100011};
         default: encode = 32'h0000_0013;
      endcase
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Architectural model that runs the program up to the self-jump
   task automatic run_model();
      logic [31:0] x [32];
      logic [31:0] mem [64];
      logic [31:0] pc;
      logic [31:0] nxt;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] res;
      logic [31:0] adr;
      logic        wr;
      logic        halted;
      row_t        r;
      dbus_t       acc;
      for (int i = 0; i < 32; i++)
         x[i] = '0;
      for (int i = 0; i < 64; i++)
         mem[i] = dmem[i];
      pc = serv_pkg::RESET_PC;
      halted = 1'b0;
      while (!halted && model_steps < 1000) begin
         exp_fetch.push_back(pc);
         model_steps++;
         r = rows[pc[31:2]];
         a = x[r.rs1];
         b = x[r.rs2];
         imm = r.imm;
         nxt = pc + 4;
         res = '0;
         wr = 1'b1;
         case (r.op)
            I_ADDI: res = a + imm;
            I_XORI: res = a ^ imm;
            I_ORI:  res = a | imm;
            I_ANDI: res = a & imm;
            I_ADD:  res = a + b;
            I_SUB:  res = a - b;
            I_XOR:  res = a ^ b;
            I_OR:   res = a | b;
            I_AND:  res = a & b;
            I_LUI:  res = imm << 12;
            I_JAL: begin
               res = pc + 4;
               nxt = pc + imm;
               halted = (imm == 0);
            end
            I_BEQ: begin
               wr = 1'b0;
               if (a == b)
                  nxt = pc + imm;
            end
            I_BNE: begin
               wr = 1'b0;
               if (a != b)
                  nxt = pc + imm;
            end
            I_LW: begin
               adr = a + imm;
               acc = '{adr: adr, dat: 32'h0, we: 1'b0};
               exp_dbus.push_back(acc);
               res = mem[adr[7:2]];
            end
            default: begin
               wr = 1'b0;
               adr = a + imm;
               acc = '{adr: adr, dat: b, we: 1'b1};
               exp_dbus.push_back(acc);
               mem[adr[7:2]] = b;
            end
         endcase
         if (wr && r.rd != 0)
            x[r.rd] = res;
         if (nxt >= 4 * N_ROWS)
            halted = 1'b1;
         pc = nxt;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Bus responder with 0 to 3 cycles of ack delay
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ibus_ack  <= 1'b0;
         dbus_ack  <= 1'b0;
         ibus_wait <= 2'd0;
         dbus_wait <= 2'd0;
      end else begin
         if (ibus_ack) begin
            ibus_ack <= 1'b0;
         end else if (o_ibus_cyc && ibus_wait != 0) begin
            ibus_wait <= ibus_wait - 1'b1;
         end else if (o_ibus_cyc) begin
            if (exp_fetch.size() > 0) begin
               check("fetch address", o_ibus_adr, exp_fetch.pop_front());
               check("data bus cyc during fetch", {31'b0, o_dbus_cyc}, 32'd0);
               if (exp_fetch.size() == 0)
                  fetch_done = 1'b1;
            end
            ibus_rdt  <= imem[o_ibus_adr[7:2]];
            ibus_ack  <= 1'b1;
            delay_rng = xorshift(delay_rng);
            ibus_wait <= delay_rng[1:0];
         end
         if (dbus_ack) begin
            dbus_ack <= 1'b0;
         end else if (o_dbus_cyc && dbus_wait != 0) begin
            dbus_wait <= dbus_wait - 1'b1;
         end else if (o_dbus_cyc) begin
            if (exp_dbus.size() == 0) begin
               errors++;
               $display("Unexpected data bus access to %h at %0t ns", o_dbus_adr, $time);
            end else begin
               dbus_exp = exp_dbus.pop_front();
               check("data address", o_dbus_adr, dbus_exp.adr);
               check("data write enable", {31'b0, o_dbus_we}, {31'b0, dbus_exp.we});
               if (dbus_exp.we)
                  check("store data", o_dbus_dat, dbus_exp.dat);
            end
            if (o_dbus_we)
               dmem[o_dbus_adr[7:2]] = o_dbus_dat;
            dbus_rdt  <= dmem[o_dbus_adr[7:2]];
            dbus_ack  <= 1'b1;
            delay_rng = xorshift(delay_rng);
            dbus_wait <= delay_rng[1:0];
         end
      end
   end

   initial begin
      wait (max_cycles > 0);
      repeat (max_cycles + 16) @(posedge clk);
      $display("Timeout: program end not reached within %0d cycles", max_cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      logic [31:0] seed;
      seed = SEED;
      for (int i = 0; i < 64; i++) begin
         seed = xorshift(seed);
         dmem[i] = seed;
         imem[i] = (i < N_ROWS) ? encode(rows[i]) : 32'h0000_0013;
      end
      run_model();
      max_cycles = 200 * model_steps;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      wait (fetch_done);
      repeat (4) @(posedge clk);
      if (exp_dbus.size() != 0) begin
         errors++;
         $display("%0d expected data bus accesses never happened", exp_dbus.size());
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== common/serv_pkg.sv ====
`default_nettype none

package serv_pkg;

   localparam int XLEN = 32;
   localparam int REG_AW = 5;
   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

   // Instruction classes kept by the core
   typedef enum logic [2:0] {
      OP_ALU_IMM,
      OP_ALU_REG,
      OP_LUI,
      OP_JAL,
      OP_BRANCH,
      OP_LOAD,
      OP_STORE,
      OP_ILLEGAL
   } op_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_RUN1,
      ST_MEM,
      ST_RUN2,
      ST_NEXT
   } state_e;

   typedef struct packed {
      op_e     op;
      alu_op_e alu_op;
      logic    use_imm;
      logic    rd_we;
      logic    two_pass;
      logic    bne;
      logic    mem_we;
   } decode_t;

   // Bit counter with its pass markers
   typedef struct packed {
      logic [$clog2(XLEN)-1:0] idx;
      logic                    first;
      logic                    last;
      logic                    en;
   } cnt_t;

endpackage

`default_nettype wire

// ==== design/serv_rf.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_rf (
   input  wire                        clk,
   input  wire                        i_arst_n,
   input  wire serv_pkg::cnt_t        i_cnt,
   input  wire [serv_pkg::REG_AW-1:0] i_rs1_addr,
   input  wire [serv_pkg::REG_AW-1:0] i_rs2_addr,
   input  wire [serv_pkg::REG_AW-1:0] i_rd_addr,
   input  wire                        i_we,
   input  wire                        i_rd,
   output logic                       o_rs1,
   output logic                       o_rs2
);

   logic [2**serv_pkg::REG_AW-1:0][serv_pkg::XLEN-1:0] regs;

   assign o_rs1 = regs[i_rs1_addr][i_cnt.idx];
   assign o_rs2 = regs[i_rs2_addr][i_cnt.idx];

   // x0 is never written so it stays at its reset value
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n)
         regs <= '0;
      else if (i_we && (i_rd_addr != '0))
         regs[i_rd_addr][i_cnt.idx] <= i_rd;
   end

endmodule

`default_nettype wire

// ==== list.f ====
common/serv_pkg.sv
serv/serv_state.sv
serv/serv_decode.sv
serv/serv_bufreg.sv
serv/serv_ctrl.sv
serv/serv_alu.sv
serv/serv_mem_if.sv
design/serv_rf.sv
serv/serv_top.sv
bench/serv_tb.sv

// ==== serv/serv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_alu (
   input  wire                    clk,
   input  wire                    i_arst_n,
   input  wire serv_pkg::cnt_t    i_cnt,
   input  wire serv_pkg::decode_t i_dec,
   input  wire                    i_rs1,
   input  wire                    i_rs2,
   input  wire                    i_imm,
   output logic                   o_rd,
   output logic                   o_cmp
);

   logic a;
   logic b;
   logic b_inv;
   logic sub;
   logic cin;
   logic sum;
   logic carry;
   logic eq;

   // LUI bits in the rs1 field are not a register
   assign a     = i_rs1 && (i_dec.op != serv_pkg::OP_LUI);
   assign b     = i_dec.use_imm ? i_imm : i_rs2;
   assign sub   = (i_dec.alu_op == serv_pkg::ALU_SUB);
   assign b_inv = b ^ sub;
   assign cin   = i_cnt.first ? sub : carry;
   assign sum   = a ^ b_inv ^ cin;

   // Running equality, full word at cnt.last
   assign o_cmp = (i_cnt.first || eq) && (i_rs1 == i_rs2);

   always_comb begin
      case (i_dec.alu_op)
         serv_pkg::ALU_AND: o_rd = a & b;
         serv_pkg::ALU_OR:  o_rd = a | b;
         serv_pkg::ALU_XOR: o_rd = a ^ b;
         default:           o_rd = sum;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry <= 1'b0;
         eq    <= 1'b0;
      end else if (i_cnt.en) begin
         carry <= (a & b_inv) | ((a ^ b_inv) & cin);
         eq    <= o_cmp;
      end
   end

endmodule

`default_nettype wire

// ==== serv/serv_bufreg.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_bufreg (
   input  wire                       clk,
   input  wire                       i_arst_n,
   input  wire serv_pkg::cnt_t       i_cnt,
   input  wire                       i_en,
   input  wire                       i_rs1,
   input  wire                       i_imm,
   output logic [serv_pkg::XLEN-1:0] o_adr
);

   logic carry;
   logic cin;
   logic sum;

   assign cin = carry && !i_cnt.first;
   assign sum = i_rs1 ^ i_imm ^ cin;

   // rs1 + imm, LSB first, lands in the top bit
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry <= 1'b0;
         o_adr <= '0;
      end else if (i_en && i_cnt.en) begin
         carry <= (i_rs1 & i_imm) | ((i_rs1 ^ i_imm) & cin);
         o_adr <= {sum, o_adr[serv_pkg::XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

// ==== serv/serv_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_ctrl (
   input  wire                       clk,
   input  wire                       i_arst_n,
   input  wire serv_pkg::cnt_t       i_cnt,
   input  wire                       i_pc_en,
   input  wire                       i_take,
   input  wire                       i_imm,
   output logic [serv_pkg::XLEN-1:0] o_pc,
   output logic                      o_link
);

   logic four;
   logic addend;
   logic c_pc;
   logic c_link;
   logic cin_pc;
   logic cin_link;
   logic pc_sum;

   // Serial constant 4 has only bit 2 set
   assign four   = (i_cnt.idx == 2);
   assign addend = i_take ? i_imm : four;

   assign cin_pc   = c_pc && !i_cnt.first;
   assign cin_link = c_link && !i_cnt.first;
   assign pc_sum   = o_pc[0] ^ addend ^ cin_pc;
   assign o_link   = o_pc[0] ^ four ^ cin_link;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_pc   <= serv_pkg::RESET_PC;
         c_pc   <= 1'b0;
         c_link <= 1'b0;
      end else if (i_pc_en) begin
         c_pc   <= (o_pc[0] & addend) | ((o_pc[0] ^ addend) & cin_pc);
         c_link <= (o_pc[0] & four) | ((o_pc[0] ^ four) & cin_link);
         o_pc   <= {pc_sum, o_pc[serv_pkg::XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

// ==== serv/serv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_decode (
   input  wire                          clk,
   input  wire                          i_arst_n,
   input  wire [serv_pkg::XLEN-1:0]     i_ibus_rdt,
   input  wire                          i_ibus_ack,
   input  wire serv_pkg::cnt_t          i_cnt,
   output serv_pkg::decode_t            o_dec,
   output logic [serv_pkg::REG_AW-1:0]  o_rs1_addr,
   output logic [serv_pkg::REG_AW-1:0]  o_rs2_addr,
   output logic [serv_pkg::REG_AW-1:0]  o_rd_addr,
   output logic                         o_imm
);

   serv_pkg::decode_t         dec_nxt;
   logic [serv_pkg::XLEN-1:0] imm_nxt;
   logic [serv_pkg::XLEN-1:0] imm_sr;
   logic [31:0]               r;
   logic [2:0]                funct3;

   assign r      = i_ibus_rdt;
   assign funct3 = r[14:12];

   always_comb begin
      dec_nxt        = '0;
      dec_nxt.op     = serv_pkg::OP_ILLEGAL;
      dec_nxt.alu_op = serv_pkg::ALU_ADD;
      imm_nxt        = {{20{r[31]}}, r[31:20]};
      case (r[6:0])
         7'b0010011, 7'b0110011: begin
            dec_nxt.op      = r[5] ? serv_pkg::OP_ALU_REG : serv_pkg::OP_ALU_IMM;
            dec_nxt.use_imm = !r[5];
            dec_nxt.rd_we   = 1'b1;
            case (funct3)
               3'b000: dec_nxt.alu_op = (r[5] && r[30]) ? serv_pkg::ALU_SUB : serv_pkg::ALU_ADD;
               3'b100: dec_nxt.alu_op = serv_pkg::ALU_XOR;
               3'b110: dec_nxt.alu_op = serv_pkg::ALU_OR;
               3'b111: dec_nxt.alu_op = serv_pkg::ALU_AND;
               default: begin
                  // Shifts and compares not supported
                  dec_nxt.op    = serv_pkg::OP_ILLEGAL;
                  dec_nxt.rd_we = 1'b0;
               end
            endcase
         end
         7'b0110111: begin
            dec_nxt.op      = serv_pkg::OP_LUI;
            dec_nxt.use_imm = 1'b1;
            dec_nxt.rd_we   = 1'b1;
            imm_nxt         = {r[31:12], 12'h000};
         end
         7'b1101111: begin
            dec_nxt.op    = serv_pkg::OP_JAL;
            dec_nxt.rd_we = 1'b1;
            imm_nxt       = {{11{r[31]}}, r[31], r[19:12], r[20], r[30:21], 1'b0};
         end
         7'b1100011: begin
            imm_nxt = {{19{r[31]}}, r[31], r[7], r[30:25], r[11:8], 1'b0};
            if (funct3[2:1] == 2'b00) begin
               dec_nxt.op       = serv_pkg::OP_BRANCH;
               dec_nxt.two_pass = 1'b1;
               dec_nxt.bne      = funct3[0];
            end
         end
         7'b0000011: begin
            if (funct3 == 3'b010) begin
               dec_nxt.op       = serv_pkg::OP_LOAD;
               dec_nxt.rd_we    = 1'b1;
               dec_nxt.two_pass = 1'b1;
            end
         end
         7'b0100011: begin
            imm_nxt = {{20{r[31]}}, r[31:25], r[11:7]};
            if (funct3 == 3'b010) begin
               dec_nxt.op     = serv_pkg::OP_STORE;
               dec_nxt.mem_we = 1'b1;
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_dec <= '0;
      else if (i_ibus_ack)
         o_dec <= dec_nxt;
   end

   // Immediate rotates so that a second pass sees it again
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_rs1_addr <= r[19:15];
         o_rs2_addr <= r[24:20];
         o_rd_addr  <= r[11:7];
         imm_sr     <= imm_nxt;
      end else if (i_cnt.en) begin
         imm_sr <= {imm_sr[0], imm_sr[serv_pkg::XLEN-1:1]};
      end
   end

   assign o_imm = imm_sr[0];

endmodule

`default_nettype wire

// ==== serv/serv_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_mem_if (
   input  wire                       clk,
   input  wire                       i_arst_n,
   input  wire serv_pkg::cnt_t       i_cnt,
   input  wire                       i_en,
   input  wire                       i_rs2,
   input  wire [serv_pkg::XLEN-1:0]  i_dbus_rdt,
   input  wire                       i_dbus_ack,
   output logic [serv_pkg::XLEN-1:0] o_dat,
   output logic                      o_rd
);

   // One register for store data in and load data out
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n)
         o_dat <= '0;
      else if (i_dbus_ack)
         o_dat <= i_dbus_rdt;
      else if (i_en && i_cnt.en)
         o_dat <= {i_rs2, o_dat[serv_pkg::XLEN-1:1]};
   end

   assign o_rd = o_dat[0];

endmodule

`default_nettype wire

// ==== serv/serv_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_state (
   input  wire                   clk,
   input  wire                   i_arst_n,
   input  wire serv_pkg::decode_t i_dec,
   input  wire                   i_ibus_ack,
   input  wire                   i_dbus_ack,
   input  wire                   i_cmp,
   output serv_pkg::cnt_t        o_cnt,
   output serv_pkg::state_e      o_state,
   output logic                  o_ibus_cyc,
   output logic                  o_dbus_cyc,
   output logic                  o_pc_en,
   output logic                  o_take
);

   serv_pkg::state_e              state;
   logic [$clog2(serv_pkg::XLEN)-1:0] idx;
   logic                          primed;
   logic                          take_r;
   logic                          en;
   logic                          last;
   logic                          mem_op;
   logic                          branch;

   assign mem_op = (i_dec.op == serv_pkg::OP_LOAD) || (i_dec.op == serv_pkg::OP_STORE);
   assign branch = (i_dec.op == serv_pkg::OP_BRANCH);

   // First RUN1 cycle is the decode cycle, counter held
   assign en   = ((state == serv_pkg::ST_RUN1) && primed) || (state == serv_pkg::ST_RUN2);
   assign last = en && (idx == '1);

   assign o_cnt      = '{idx: idx, first: en && (idx == '0), last: last, en: en};
   assign o_state    = state;
   assign o_ibus_cyc = (state == serv_pkg::ST_FETCH);
   assign o_dbus_cyc = (state == serv_pkg::ST_MEM);

   // Branches write the PC in RUN2, everything else in RUN1
   assign o_pc_en = en && (branch ? (state == serv_pkg::ST_RUN2) : (state == serv_pkg::ST_RUN1));
   assign o_take  = (state == serv_pkg::ST_RUN2) ? take_r : (i_dec.op == serv_pkg::OP_JAL);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state  <= serv_pkg::ST_FETCH;
         idx    <= '0;
         primed <= 1'b0;
         take_r <= 1'b0;
      end else begin
         if (en)
            idx <= idx + 1'b1;
         case (state)
            serv_pkg::ST_FETCH: begin
               primed <= 1'b0;
               if (i_ibus_ack)
                  state <= serv_pkg::ST_RUN1;
            end
            serv_pkg::ST_RUN1: begin
               primed <= 1'b1;
               if (last) begin
                  take_r <= i_cmp ^ i_dec.bne;
                  if (mem_op)
                     state <= serv_pkg::ST_MEM;
                  else if (i_dec.two_pass)
                     state <= serv_pkg::ST_RUN2;
                  else
                     state <= serv_pkg::ST_NEXT;
               end
            end
            serv_pkg::ST_MEM: begin
               if (i_dbus_ack)
                  state <= i_dec.two_pass ? serv_pkg::ST_RUN2 : serv_pkg::ST_NEXT;
            end
            serv_pkg::ST_RUN2: begin
               if (last)
                  state <= serv_pkg::ST_NEXT;
            end
            default: state <= serv_pkg::ST_FETCH;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== serv/serv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_top (
   input  wire                       clk,
   input  wire                       i_arst_n,
   output logic [serv_pkg::XLEN-1:0] o_ibus_adr,
   output logic                      o_ibus_cyc,
   input  wire  [serv_pkg::XLEN-1:0] i_ibus_rdt,
   input  wire                       i_ibus_ack,
   output logic [serv_pkg::XLEN-1:0] o_dbus_adr,
   output logic [serv_pkg::XLEN-1:0] o_dbus_dat,
   output logic                      o_dbus_we,
   output logic                      o_dbus_cyc,
   input  wire  [serv_pkg::XLEN-1:0] i_dbus_rdt,
   input  wire                       i_dbus_ack
);

   serv_pkg::decode_t           dec;
   serv_pkg::cnt_t              cnt;
   serv_pkg::state_e            state;
   logic [serv_pkg::REG_AW-1:0] rs1_addr;
   logic [serv_pkg::REG_AW-1:0] rs2_addr;
   logic [serv_pkg::REG_AW-1:0] rd_addr;
   logic                        rs1;
   logic                        rs2;
   logic                        imm;
   logic                        rd;
   logic                        rd_en;
   logic                        cmp;
   logic                        pc_en;
   logic                        take;
   logic                        link;
   logic                        alu_rd;
   logic                        mem_rd;
   logic                        mem_op;
   logic                        fetch_ack;
   logic                        load_ack;

   assign mem_op    = (dec.op == serv_pkg::OP_LOAD) || (dec.op == serv_pkg::OP_STORE);
   assign fetch_ack = i_ibus_ack && o_ibus_cyc;
   assign load_ack  = i_dbus_ack && o_dbus_cyc && !dec.mem_we;
   assign o_dbus_we = dec.mem_we;

   always_comb begin
      case (dec.op)
         serv_pkg::OP_JAL:  rd = link;
         serv_pkg::OP_LOAD: rd = mem_rd;
         default:           rd = alu_rd;
      endcase
   end

   // Loads write rd from the second pass
   assign rd_en = dec.rd_we && cnt.en &&
                  ((dec.op == serv_pkg::OP_LOAD) ? (state == serv_pkg::ST_RUN2)
                                                  : (state == serv_pkg::ST_RUN1));

   serv_state u_state (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_dec      (dec),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_cmp      (cmp),
      .o_cnt      (cnt),
      .o_state    (state),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_pc_en    (pc_en),
      .o_take     (take)
   );

   serv_decode u_decode (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (fetch_ack),
      .i_cnt      (cnt),
      .o_dec      (dec),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr),
      .o_imm      (imm)
   );

   serv_bufreg u_bufreg (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_cnt    (cnt),
      .i_en     (mem_op && (state == serv_pkg::ST_RUN1)),
      .i_rs1    (rs1),
      .i_imm    (imm),
      .o_adr    (o_dbus_adr)
   );

   serv_ctrl u_ctrl (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_cnt    (cnt),
      .i_pc_en  (pc_en),
      .i_take   (take),
      .i_imm    (imm),
      .o_pc     (o_ibus_adr),
      .o_link   (link)
   );

   serv_alu u_alu (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_cnt    (cnt),
      .i_dec    (dec),
      .i_rs1    (rs1),
      .i_rs2    (rs2),
      .i_imm    (imm),
      .o_rd     (alu_rd),
      .o_cmp    (cmp)
   );

   serv_mem_if u_mem_if (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_cnt      (cnt),
      .i_en       (mem_op),
      .i_rs2      (rs2),
      .i_dbus_rdt (i_dbus_rdt),
      .i_dbus_ack (load_ack),
      .o_dat      (o_dbus_dat),
      .o_rd       (mem_rd)
   );

   serv_rf u_rf (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_we       (rd_en),
      .i_rd       (rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

endmodule

`default_nettype wire
